/* Bender.yml */
package:
  name: cgmii_tx_gen

sources:
  - rtl/cgmii_pkg.sv
  - rtl/frame_seq_fsm.sv
  - rtl/run_counter.sv
  - rtl/block_encoder.sv
  - rtl/cgmii_tx_gen.sv
  - target: test
    files:
      - test/tb_cgmii_tx_gen.sv

/* compile.f */
rtl/cgmii_pkg.sv
rtl/frame_seq_fsm.sv
rtl/run_counter.sv
rtl/block_encoder.sv
rtl/cgmii_tx_gen.sv
test/tb_cgmii_tx_gen.sv

/* rtl/block_encoder.sv */
`default_nettype none
`timescale 1ns/10ps

module block_encoder (
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire cgmii_pkg::block_kind_t i_kind,
	input  wire cgmii_pkg::term_pos_t   i_term_pos,
	input  wire cgmii_pkg::data_word_t  i_payload,
	output cgmii_pkg::cgmii_block_t     o_block
);
	import cgmii_pkg::*;

	cgmii_block_t block_d;

	// Terminate block with payload before lane pos and idles after it
	function automatic cgmii_block_t term_block(
		input data_word_t payload,
		input term_pos_t  pos
	);
		cgmii_block_t blk;
		int           hi;
		blk = IDLE_BLOCK;
		for (int lane = 0; lane < LANES; lane++) begin
			hi = (LANES - 1 - lane) * BYTE_W;
			if (lane < pos) begin
				blk.data[hi +: BYTE_W]    = payload[hi +: BYTE_W];
				blk.ctrl[LANES - 1 - lane] = 1'b0;
			end else if (lane == pos) begin
				blk.data[hi +: BYTE_W]    = TERM_CHAR;
				blk.ctrl[LANES - 1 - lane] = 1'b1;
			end else begin
				blk.data[hi +: BYTE_W]    = IDLE_CHAR;
				blk.ctrl[LANES - 1 - lane] = 1'b1;
			end
		end
		return blk;
	endfunction

	// Start character in lane 0 then payload lanes 1 to 7
	function automatic cgmii_block_t start_block(input data_word_t payload);
		cgmii_block_t blk;
		blk.ctrl = START_MASK;
		blk.data = {START_CHAR, payload[DATA_W-BYTE_W-1:0]};
		return blk;
	endfunction

	always_comb begin
		case (i_kind)
			KIND_IDLE: begin
				block_d = IDLE_BLOCK;
			end
			KIND_START: begin
				block_d = start_block(i_payload);
			end
			KIND_DATA: begin
				block_d.ctrl = DATA_MASK;
				block_d.data = i_payload;               // Payload passes as given
			end
			KIND_TERM: begin
				block_d = term_block(i_payload, i_term_pos);
			end
			KIND_ERROR: begin
				block_d = ERROR_BLOCK;
			end
			KIND_ORDSET: begin
				block_d = ORDSET_BLOCK;
			end
			default: begin
				block_d = IDLE_BLOCK;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_block <= IDLE_BLOCK;                     // Inactive line
		end else begin
			o_block <= block_d;
		end
	end

endmodule

`default_nettype wire

/* rtl/cgmii_pkg.sv */
`default_nettype none

package cgmii_pkg;

	localparam int LANES     = 8;                 // Byte lanes per block
	localparam int BYTE_W    = 8;
	localparam int DATA_W    = LANES * BYTE_W;
	localparam int RUN_LEN_W = 12;

	typedef logic [RUN_LEN_W-1:0] run_len_t;      // Run length minus one
	typedef logic [2:0]           term_pos_t;     // Lane of the terminate character
	typedef logic [DATA_W-1:0]    data_word_t;    // Lane 0 in the top byte
	typedef logic [LANES-1:0]     ctrl_mask_t;    // Bit 7 is lane 0
	typedef logic [BYTE_W-1:0]    byte_t;

	typedef struct packed {
		run_len_t  n_idle;
		run_len_t  n_data;
		run_len_t  n_error;
		term_pos_t term_pos;
	} frame_cfg_t;

	typedef struct packed {
		ctrl_mask_t ctrl;
		data_word_t data;
	} cgmii_block_t;

	typedef logic [2:0] block_kind_t;

	localparam block_kind_t KIND_IDLE   = 3'd0;
	localparam block_kind_t KIND_START  = 3'd1;
	localparam block_kind_t KIND_DATA   = 3'd2;
	localparam block_kind_t KIND_TERM   = 3'd3;
	localparam block_kind_t KIND_ERROR  = 3'd4;
	localparam block_kind_t KIND_ORDSET = 3'd5;

	typedef logic [3:0] force_cmd_t;

	localparam force_cmd_t FORCE_NONE   = 4'b0000;
	localparam force_cmd_t FORCE_ERROR  = 4'b0001;
	localparam force_cmd_t FORCE_ORDSET = 4'b0010;
	localparam force_cmd_t FORCE_START  = 4'b0100;
	localparam force_cmd_t FORCE_TERM   = 4'b1111;

	localparam byte_t START_CHAR = 8'hFB;
	localparam byte_t TERM_CHAR  = 8'hFD;
	localparam byte_t IDLE_CHAR  = 8'h07;

	localparam data_word_t IDLE_DATA   = {LANES{IDLE_CHAR}};
	localparam data_word_t ERROR_DATA  = 64'hFEFE_FEFE_FEFE_FEFE;
	localparam data_word_t ORDSET_DATA = 64'h9C68_7973_0000_0000;   // Sequence ordered set

	localparam ctrl_mask_t IDLE_MASK   = 8'hFF;
	localparam ctrl_mask_t ERROR_MASK  = 8'hFF;
	localparam ctrl_mask_t ORDSET_MASK = 8'h80;
	localparam ctrl_mask_t START_MASK  = 8'h80;
	localparam ctrl_mask_t DATA_MASK   = 8'h00;

	localparam cgmii_block_t IDLE_BLOCK   = '{ctrl: IDLE_MASK, data: IDLE_DATA};
	localparam cgmii_block_t ERROR_BLOCK  = '{ctrl: ERROR_MASK, data: ERROR_DATA};
	localparam cgmii_block_t ORDSET_BLOCK = '{ctrl: ORDSET_MASK, data: ORDSET_DATA};

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_TERM,
		ST_ERROR
	} seq_state_t;

endpackage

`default_nettype wire

/* rtl/cgmii_tx_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module cgmii_tx_gen (
	input  wire                        i_clock,
	input  wire                        i_reset,
	input  wire cgmii_pkg::frame_cfg_t i_cfg,
	input  wire cgmii_pkg::force_cmd_t i_force,
	input  wire cgmii_pkg::data_word_t i_payload,
	output cgmii_pkg::cgmii_block_t    o_block
);
	import cgmii_pkg::*;

	logic        counter_load;
	run_len_t    counter_value;
	logic        run_last;
	block_kind_t kind;                             // Block chosen for this cycle
	term_pos_t   term_pos;

	frame_seq_fsm fsm_i (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_cfg           (i_cfg),
		.i_force         (i_force),
		.i_run_last      (run_last),
		.o_counter_load  (counter_load),
		.o_counter_value (counter_value),
		.o_kind          (kind),
		.o_term_pos      (term_pos)
	);

	run_counter run_counter_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_load  (counter_load),
		.i_value (counter_value),
		.o_last  (run_last)
	);

	// One cycle from sampled inputs to the output block
	block_encoder encoder_i (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_kind     (kind),
		.i_term_pos (term_pos),
		.i_payload  (i_payload),
		.o_block    (o_block)
	);

endmodule

`default_nettype wire

/* rtl/frame_seq_fsm.sv */
`default_nettype none
`timescale 1ns/10ps

module frame_seq_fsm (
	input  wire                        i_clock,
	input  wire                        i_reset,
	input  wire cgmii_pkg::frame_cfg_t i_cfg,
	input  wire cgmii_pkg::force_cmd_t i_force,
	input  wire                        i_run_last,     // Current block ends its run
	output logic                       o_counter_load,
	output cgmii_pkg::run_len_t        o_counter_value,
	output cgmii_pkg::block_kind_t     o_kind,
	output cgmii_pkg::term_pos_t       o_term_pos
);
	import cgmii_pkg::*;

	seq_state_t  state_q;
	seq_state_t  state_d;
	frame_cfg_t  cfg_q;                                // Config of the frame in progress
	logic        enter_idle;
	logic        prime_idle;
	logic        load_run;
	run_len_t    load_value;

	always_comb begin
		state_d    = state_q;
		o_kind     = KIND_IDLE;
		enter_idle = 1'b0;
		load_run   = 1'b0;
		load_value = cfg_q.n_data;

		// Force codes take priority over the frame sequence
		case (i_force)
			FORCE_ERROR: begin
				o_kind = KIND_ERROR;
				if (cfg_q.n_error == '0) begin
					enter_idle = 1'b1;                 // Burst is this block only
				end else begin
					state_d    = ST_ERROR;
					load_run   = 1'b1;
					load_value = cfg_q.n_error - 1'b1;    // This block counts as the first
				end
			end
			FORCE_ORDSET: begin
				o_kind     = KIND_ORDSET;
				enter_idle = 1'b1;
			end
			FORCE_START: begin
				o_kind     = KIND_START;
				state_d    = ST_DATA;
				load_run   = 1'b1;
				load_value = cfg_q.n_data;
			end
			FORCE_TERM: begin
				o_kind     = KIND_TERM;
				enter_idle = 1'b1;
			end
			default: begin
				case (state_q)
					ST_IDLE: begin
						o_kind = KIND_IDLE;
						if (i_run_last) begin
							state_d = ST_START;
						end
					end
					ST_START: begin
						o_kind     = KIND_START;
						state_d    = ST_DATA;
						load_run   = 1'b1;
						load_value = cfg_q.n_data;
					end
					ST_DATA: begin
						o_kind = KIND_DATA;
						if (i_run_last) begin
							state_d = ST_TERM;
						end
					end
					ST_TERM: begin
						o_kind     = KIND_TERM;
						enter_idle = 1'b1;
					end
					ST_ERROR: begin
						o_kind = KIND_ERROR;
						if (i_run_last) begin
							enter_idle = 1'b1;
						end
					end
					default: begin
						enter_idle = 1'b1;                 // Recover to a fresh idle run
					end
				endcase
			end
		endcase

		if (enter_idle) begin
			state_d = ST_IDLE;
		end
	end

	// Reset primes the counter with the first idle run
	assign prime_idle      = enter_idle | i_reset;
	assign o_counter_load  = load_run | prime_idle;
	assign o_counter_value = prime_idle ? i_cfg.n_idle : load_value;
	assign o_term_pos      = cfg_q.term_pos;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge i_clock) begin
		if (prime_idle) begin
			cfg_q <= i_cfg;                            // New config at each idle run
		end
	end

endmodule

`default_nettype wire

/* rtl/run_counter.sv */
`default_nettype none
`timescale 1ns/10ps

module run_counter (
	input  wire                      i_clock,
	input  wire                      i_reset,
	input  wire                      i_load,
	input  wire cgmii_pkg::run_len_t i_value,
	output logic                     o_last
);
	import cgmii_pkg::*;

	run_len_t count;                               // Blocks left in the run after this one

	// Load has priority so the first idle run is primed during reset
	always_ff @(posedge i_clock) begin
		if (i_load) begin
			count <= i_value;
		end else if (i_reset) begin
			count <= '0;
		end else if (count != '0) begin
			count <= count - 1'b1;                     // Holds at zero
		end
	end

	assign o_last = (count == '0);

endmodule

`default_nettype wire

/* test/tb_cgmii_tx_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_cgmii_tx_gen;
	import cgmii_pkg::*;

	// Frames per run times 14 cycles for the longest frame, with margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int PH_IDLE  = 0;
	localparam int PH_START = 1;
	localparam int PH_DATA  = 2;
	localparam int PH_TERM  = 3;
	localparam int PH_ERROR = 4;
	localparam cgmii_block_t IDLE_EXP   = {8'hFF, {8{8'h07}}};
	localparam cgmii_block_t ERROR_EXP  = {8'hFF, {8{8'hFE}}};
	localparam cgmii_block_t ORDSET_EXP = {8'h80, 64'h9C68_7973_0000_0000};

	logic         clock;
	logic         reset;
	frame_cfg_t   cfg;
	force_cmd_t   force_cmd;
	data_word_t   payload;
	cgmii_block_t out_block;

	integer       seed;
	string        test_name;
	cgmii_block_t expected;                    // Block predicted for the next edge
	logic         model_valid = 1'b0;
	frame_cfg_t   cfg_m;                       // Config of the modelled frame
	int           phase;
	int           left;                        // Blocks still due in this phase
	int           frames_done = 0;
	int           cycle_count = 0;

	cgmii_tx_gen dut_i (
		.i_clock   (clock),
		.i_reset   (reset),
		.i_cfg     (cfg),
		.i_force   (force_cmd),
		.i_payload (payload),
		.o_block   (out_block)
	);

	always #4 clock = ~clock;

	// Payload lanes up to p, the terminate character, then idle fill
	function automatic cgmii_block_t term_exp(input data_word_t word, input int pos);
		data_word_t  built;
		logic [7:0]  lane_byte;
		built = '0;
		for (int lane = 0; lane < 8; lane++) begin
			if (lane < pos)
				lane_byte = word[63 - 8 * lane -: 8];
			else if (lane == pos)
				lane_byte = 8'hFD;
			else
				lane_byte = 8'h07;
			built = {built[55:0], lane_byte};
		end
		return {8'hFF >> pos, built};
	endfunction

	task automatic start_idle_run();
		phase = PH_IDLE;
		cfg_m = cfg;                           // Config taken at each idle run
		left  = int'(cfg.n_idle) + 1;
	endtask

	// Reference model of the frame sequence and the force codes
	always @(posedge clock) begin
		model_valid = 1'b1;
		if (reset) begin
			expected = IDLE_EXP;
			start_idle_run();
		end else begin
			case (force_cmd)
				FORCE_ERROR: begin
					expected = ERROR_EXP;
					left     = int'(cfg_m.n_error);
					if (left == 0) start_idle_run();
					else phase = PH_ERROR;
				end
				FORCE_ORDSET: begin
					expected = ORDSET_EXP;
					start_idle_run();
				end
				FORCE_START: begin
					expected = {8'h80, 8'hFB, payload[55:0]};
					phase    = PH_DATA;
					left     = int'(cfg_m.n_data) + 1;
				end
				FORCE_TERM: begin
					expected    = term_exp(payload, int'(cfg_m.term_pos));
					frames_done = frames_done + 1;
					start_idle_run();
				end
				default: begin
					case (phase)
						PH_IDLE: begin
							expected = IDLE_EXP;
							left     = left - 1;
							if (left == 0) phase = PH_START;
						end
						PH_START: begin
							expected = {8'h80, 8'hFB, payload[55:0]};
							phase    = PH_DATA;
							left     = int'(cfg_m.n_data) + 1;
						end
						PH_DATA: begin
							expected = {8'h00, payload};
							left     = left - 1;
							if (left == 0) phase = PH_TERM;
						end
						PH_TERM: begin
							expected    = term_exp(payload, int'(cfg_m.term_pos));
							frames_done = frames_done + 1;
							start_idle_run();
						end
						default: begin
							expected = ERROR_EXP;
							left     = left - 1;
							if (left == 0) start_idle_run();
						end
					endcase
				end
			endcase
		end
	end

	check_block: assert property (@(posedge clock) !model_valid || out_block == expected)
		else begin
			$display("CHECK FAILED test=%s expected=%h actual=%h", test_name,
				$sampled(expected), $sampled(out_block));
			$display("Something failed");
			$fatal(1, "Stopping at the first mismatch");
		end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic next_cycle();
		logic [31:0] upper;
		logic [31:0] lower;
		@(negedge clock);
		upper   = $random(seed);
		lower   = $random(seed);
		payload = {upper, lower};             // Fresh payload every cycle
	endtask

	task automatic rand_cfg();
		cfg.n_idle   = run_len_t'($unsigned($random(seed)) % 6);
		cfg.n_data   = run_len_t'($unsigned($random(seed)) % 6);
		cfg.n_error  = run_len_t'($unsigned($random(seed)) % 6);
		cfg.term_pos = term_pos_t'($unsigned($random(seed)) % 8);
	endtask

	task automatic wait_frames(input int count);
		int target;
		target = frames_done + count;
		while (frames_done < target) next_cycle();
	endtask

	task automatic wait_phase(input int ph);
		while (phase != ph) next_cycle();
	endtask

	task automatic apply_force(input force_cmd_t cmd, input int cycles);
		force_cmd = cmd;
		repeat (cycles) next_cycle();
		force_cmd = FORCE_NONE;
	endtask

	initial begin
		seed      = 32'h4666174c;
		clock     = 1'b0;
		reset     = 1'b1;
		cfg       = '0;
		force_cmd = FORCE_NONE;
		payload   = '0;
		test_name = "reset";
		rand_cfg();
		repeat (4) next_cycle();
		reset = 1'b0;
		wait_frames(1);

		test_name = "normal_frames";
		repeat (20) begin
			rand_cfg();
			wait_frames(1);
		end

		test_name = "term_formats";
		for (int p = 0; p < 8; p++) begin
			rand_cfg();
			cfg.term_pos = term_pos_t'(p);
			wait_frames(2);                    // Next idle run takes the new config
		end

		test_name = "forced_error";
		for (int ph = PH_IDLE; ph <= PH_TERM; ph++) begin
			rand_cfg();
			wait_phase(ph);
			apply_force(FORCE_ERROR, 1);
			wait_frames(1);
		end

		test_name = "ordset_and_start";
		wait_phase(PH_IDLE);
		apply_force(FORCE_ORDSET, 1);
		wait_frames(1);
		wait_phase(PH_IDLE);
		apply_force(FORCE_START, 1);
		wait_frames(1);

		test_name = "term_and_held_force";
		rand_cfg();
		cfg.n_error = run_len_t'(4);           // Five-block bursts fall out of step with the hold
		wait_phase(PH_DATA);
		apply_force(FORCE_TERM, 1);
		wait_frames(1);
		apply_force(FORCE_ERROR, 7);
		wait_frames(1);
		apply_force(4'b0011, 3);              // Unknown code runs as no force
		wait_frames(1);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
